// File: rtl/muldiv_pkg.sv
// ~~~~~~~~~~~~~~~~~~~~
// muldiv package
// shared widths, operation codes and the request/result
// structs of the multiply/divide unit
// ~~~~~~~~~~~~~~~~~~~~

`default_nettype none

package muldiv_pkg;

   localparam int WORD_W = 32;

   typedef logic [WORD_W-1:0]   word_t;   // operand or register value
   typedef logic [2*WORD_W-1:0] dword_t;  // product, or remainder and quotient

   // issued operation
   typedef enum logic [2:0] {
      md_none  = 3'd0,
      md_mult  = 3'd1,
      md_multu = 3'd2,
      md_div   = 3'd3,
      md_divu  = 3'd4,
      md_mthi  = 3'd5,
      md_mtlo  = 3'd6
   } md_op_e;

   // a is multiplicand or dividend, b is multiplier or divisor
   typedef struct packed {
      md_op_e op;
      word_t  a;
      word_t  b;
   } md_req_t;

   typedef struct packed {
      word_t hi;
      word_t lo;
   } md_res_t;

   // iterative divider states
   typedef enum logic [1:0] {
      div_idle = 2'd0,
      div_run  = 2'd1,
      div_fix  = 2'd2
   } div_state_e;

endpackage

`default_nettype wire

// File: rtl/mul_pipe.sv
// ~~~~~~~~~~~~~~~~~~~~
// mul_pipe
// 33x33 signed multiplier covering mult and multu,
// product and valid carried through MUL_STAGES registers
// ~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ps
`default_nettype none

module mul_pipe
   import muldiv_pkg::*;
#(
   parameter int MUL_STAGES = 2
) (
   input  logic   aclk,
   input  logic   rst,
   input  logic   start,
   input  logic   is_signed,
   input  word_t  a,
   input  word_t  b,
   output logic   done,
   output dword_t prod
);

   logic signed [32:0] a_ext;
   logic signed [32:0] b_ext;
   logic signed [65:0] full;

   logic [MUL_STAGES-1:0] vld;
   dword_t                prod_q [MUL_STAGES];

   // sign or zero extension, then one signed multiply for both flavours
   always_comb begin
      a_ext = {is_signed & a[31], a};
      b_ext = {is_signed & b[31], b};
      full  = a_ext * b_ext;
   end

   always_ff @(posedge aclk or negedge rst) begin
      if (!rst) begin
         vld <= '0;
      end else begin
         vld[0] <= start;
         for (int i = 1; i < MUL_STAGES; i++) begin
            vld[i] <= vld[i-1];
         end
      end
   end

   // product payload, follows valid
   always_ff @(posedge aclk) begin
      prod_q[0] <= full[63:0];   // upper two bits are pure sign
      for (int i = 1; i < MUL_STAGES; i++) begin
         prod_q[i] <= prod_q[i-1];
      end
   end

   assign done = vld[MUL_STAGES-1];
   assign prod = prod_q[MUL_STAGES-1];

endmodule

`default_nettype wire

// File: rtl/div_iter.sv
// ~~~~~~~~~~~~~~~~~~~~
// div_iter
// 32-step restoring divider, signed or unsigned
// operands reduced to magnitudes on load, signs put back in the fix state
// divide by zero gives all-ones quotient and dividend as remainder
// ~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ps
`default_nettype none

module div_iter
   import muldiv_pkg::*;
(
   input  logic    aclk,
   input  logic    rst,
   input  logic    start,
   input  logic    is_signed,
   input  word_t   dividend,
   input  word_t   divisor,
   output logic    done,
   output md_res_t res
);

   div_state_e state;
   logic [4:0] step_cnt;

   word_t rem;     // partial remainder
   word_t quo;     // dividend bits shift out, quotient bits shift in
   word_t dvsr;
   logic  neg_q;
   logic  neg_r;

   word_t       abs_a;
   word_t       abs_b;
   logic [32:0] rem_sh;
   logic [33:0] diff;

   always_comb begin
      abs_a  = (is_signed && dividend[31]) ? -dividend : dividend;
      abs_b  = (is_signed && divisor[31])  ? -divisor  : divisor;
      rem_sh = {rem, quo[31]};
      diff   = {1'b0, rem_sh} - {2'b00, dvsr};
   end

   always_ff @(posedge aclk or negedge rst) begin
      if (!rst) begin
         state    <= div_idle;
         step_cnt <= '0;
         done     <= 1'b0;
      end else begin
         done <= 1'b0;
         case (state)
            div_idle: begin
               if (start) begin
                  state    <= div_run;
                  step_cnt <= '0;
               end
            end
            div_run: begin
               step_cnt <= step_cnt + 5'd1;
               if (step_cnt == 5'd31)
                  state <= div_fix;
            end
            div_fix: begin
               state <= div_idle;
               done  <= 1'b1;   // result registers settle on this edge
            end
            default: state <= div_idle;
         endcase
      end
   end

   // datapath
   always_ff @(posedge aclk) begin
      case (state)
         div_idle: begin
            if (start) begin
               rem   <= '0;
               quo   <= abs_a;
               dvsr  <= abs_b;
               // no quotient sign flip on a zero divisor, keeps all ones
               neg_q <= is_signed && (dividend[31] ^ divisor[31]) && (divisor != '0);
               neg_r <= is_signed && dividend[31];
            end
         end
         div_run: begin
            if (!diff[33]) begin   // trial subtract fits
               rem <= diff[31:0];
               quo <= {quo[30:0], 1'b1};
            end else begin
               rem <= rem_sh[31:0];
               quo <= {quo[30:0], 1'b0};
            end
         end
         div_fix: begin
            if (neg_q)
               quo <= -quo;
            if (neg_r)
               rem <= -rem;
         end
         default: ;
      endcase
   end

   assign res.hi = rem;
   assign res.lo = quo;

   a_start_idle: assert property (@(posedge aclk) disable iff (!rst)
      start |-> state == div_idle);

   // 1 load, 32 steps, 1 fix, then the write edge
   a_done_lat: assert property (@(posedge aclk) disable iff (!rst)
      start |=> !done [*33] ##1 done);

endmodule

`default_nettype wire

// File: rtl/hilo_regs.sv
// ~~~~~~~~~~~~~~~~~~~~
// hilo_regs
// HI/LO register pair, loaded as a pair by result writes
// or one at a time by mthi/mtlo
// ~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ps
`default_nettype none

module hilo_regs
   import muldiv_pkg::*;
(
   input  logic    aclk,
   input  logic    rst,
   input  logic    wr_res,
   input  md_res_t res,
   input  logic    wr_hi,
   input  logic    wr_lo,
   input  word_t   wr_data,
   output md_res_t hilo
);

   word_t hi_q;
   word_t lo_q;

   always_ff @(posedge aclk or negedge rst) begin
      if (!rst) begin
         hi_q <= '0;
         lo_q <= '0;
      end else if (wr_res) begin
         hi_q <= res.hi;
         lo_q <= res.lo;
      end else begin
         if (wr_hi)
            hi_q <= wr_data;   // mthi
         if (wr_lo)
            lo_q <= wr_data;   // mtlo
      end
   end

   assign hilo.hi = hi_q;
   assign hilo.lo = lo_q;

   // controller must have dropped the move-to already
   a_no_wr_clash: assert property (@(posedge aclk) disable iff (!rst)
      !(wr_res && (wr_hi || wr_lo)));

endmodule

`default_nettype wire

// File: rtl/muldiv_ctrl.sv
// ~~~~~~~~~~~~~~~~~~~~
// muldiv_ctrl
// decodes issued operations, starts multiplier or divider,
// keeps busy over a divide and steers results into HI/LO
// ~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ps
`default_nettype none

module muldiv_ctrl
   import muldiv_pkg::*;
#(
   parameter int MUL_STAGES = 2
) (
   input  logic    aclk,
   input  logic    rst,
   input  logic    issue,
   input  md_req_t req,
   output logic    busy,
   output logic    done,
   output logic    mul_start,
   output logic    mul_signed,
   output word_t   mul_a,
   output word_t   mul_b,
   input  logic    mul_done,
   input  dword_t  mul_prod,
   output logic    div_start,
   output logic    div_signed,
   output word_t   div_a,
   output word_t   div_b,
   input  logic    div_done,
   input  md_res_t div_res,
   output logic    wr_res,
   output md_res_t res,
   output logic    wr_hi,
   output logic    wr_lo,
   output word_t   wr_data
);

   localparam int CNT_W = $clog2(MUL_STAGES + 1);

   logic             busy_q;
   logic             accept;
   logic [CNT_W-1:0] mul_cnt;   // multiplies in flight

   assign busy   = busy_q & ~div_done;   // low again in the done cycle
   assign accept = issue & ~busy;

   assign mul_start  = accept && (req.op == md_mult || req.op == md_multu);
   assign mul_signed = (req.op == md_mult);
   assign mul_a      = req.a;
   assign mul_b      = req.b;

   assign div_start  = accept && (req.op == md_div || req.op == md_divu);
   assign div_signed = (req.op == md_div);
   assign div_a      = req.a;
   assign div_b      = req.b;

   // product high word to HI; divider gives remainder in hi, quotient in lo
   assign wr_res = mul_done | div_done;
   assign res    = mul_done ? md_res_t'(mul_prod) : div_res;
   assign done   = wr_res;

   assign wr_hi   = accept && (req.op == md_mthi) && !wr_res;
   assign wr_lo   = accept && (req.op == md_mtlo) && !wr_res;
   assign wr_data = req.a;

   always_ff @(posedge aclk or negedge rst) begin
      if (!rst) begin
         busy_q  <= 1'b0;
         mul_cnt <= '0;
      end else begin
         if (div_start)
            busy_q <= 1'b1;
         else if (div_done)
            busy_q <= 1'b0;
         mul_cnt <= mul_cnt + CNT_W'(mul_start) - CNT_W'(mul_done);
      end
   end

   // no multiply can be launched while a divide runs
   a_div_mul_clash: assert property (@(posedge aclk) disable iff (!rst)
      div_done |-> (mul_cnt == '0 && !mul_done));

endmodule

`default_nettype wire

// File: rtl/muldiv_top.sv
// ~~~~~~~~~~~~~~~~~~~~
// muldiv_top
// multiply/divide unit with its own HI/LO registers
// ~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ps
`default_nettype none

module muldiv_top
   import muldiv_pkg::*;
#(
   parameter int MUL_STAGES = 2   // 1 to 3
) (
   input  logic    aclk,
   input  logic    rst,
   input  logic    issue,
   input  md_req_t req,
   output logic    busy,
   output logic    done,
   output md_res_t hilo
);

   logic    mul_start, mul_signed, mul_done;
   word_t   mul_a, mul_b;
   dword_t  mul_prod;
   logic    div_start, div_signed, div_done;
   word_t   div_a, div_b;
   md_res_t div_res;
   logic    wr_res, wr_hi, wr_lo;
   md_res_t res;
   word_t   wr_data;

   muldiv_ctrl #(.MUL_STAGES(MUL_STAGES)) u_ctrl (
      .aclk(aclk), .rst(rst), .issue(issue), .req(req), .busy(busy), .done(done),
      .mul_start(mul_start), .mul_signed(mul_signed), .mul_a(mul_a), .mul_b(mul_b),
      .mul_done(mul_done), .mul_prod(mul_prod),
      .div_start(div_start), .div_signed(div_signed), .div_a(div_a), .div_b(div_b),
      .div_done(div_done), .div_res(div_res),
      .wr_res(wr_res), .res(res), .wr_hi(wr_hi), .wr_lo(wr_lo), .wr_data(wr_data)
   );

   mul_pipe #(.MUL_STAGES(MUL_STAGES)) u_mul (
      .aclk(aclk), .rst(rst), .start(mul_start), .is_signed(mul_signed),
      .a(mul_a), .b(mul_b), .done(mul_done), .prod(mul_prod)
   );

   div_iter u_div (
      .aclk(aclk), .rst(rst), .start(div_start), .is_signed(div_signed),
      .dividend(div_a), .divisor(div_b), .done(div_done), .res(div_res)
   );

   hilo_regs u_hilo (
      .aclk(aclk), .rst(rst), .wr_res(wr_res), .res(res),
      .wr_hi(wr_hi), .wr_lo(wr_lo), .wr_data(wr_data), .hilo(hilo)
   );

endmodule

`default_nettype wire

// File: sim/tb_muldiv.sv
// ~~~~~~~~~~~~~~~~~~~~
// tb_muldiv
// random multiply, divide and move-to traffic into the multiply/divide
// unit, HI/LO, done and busy checked every cycle against a model
// ~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ps
`default_nettype none

module tb_muldiv
   import muldiv_pkg::*;
#(
   parameter int MUL_STAGES = 2
) ();

   localparam int CLK_PERIOD = 20;
   localparam int DIV_LAT    = 34;
   localparam int N_MUL      = 40;
   localparam int N_BURST    = 8;
   localparam int N_DIV      = 30;
   localparam int N_MT       = 16;
   localparam int N_BUSY     = 4;
   localparam int TIMEOUT_CYC = N_MUL * (MUL_STAGES + 5) + N_BURST * (MUL_STAGES + 12)
                              + (N_DIV + N_BUSY + 6) * (DIV_LAT + 8) + N_MT * 5 + 200;

   localparam logic [1:0] K_MUL = 2'd0;
   localparam logic [1:0] K_DIV = 2'd1;
   localparam logic [1:0] K_HI  = 2'd2;
   localparam logic [1:0] K_LO  = 2'd3;

   typedef struct packed {
      logic [31:0] due;    // edge at which HI/LO take the value
      logic [1:0]  kind;
      logic [63:0] val;
   } pend_t;

   logic    aclk = 1'b0;
   logic    rst;
   logic    issue;
   md_req_t req;
   logic    busy;
   logic    done;
   md_res_t hilo;

   pend_t       pend[$];   // accepted operations not yet written
   pend_t       head;
   logic [31:0] cyc = '0;
   word_t       model_hi;
   word_t       model_lo;
   logic        exp_done;
   logic        exp_busy;
   string       test_name;
   int          err_cnt = 0;

   muldiv_top #(.MUL_STAGES(MUL_STAGES)) DUT (
      .aclk(aclk), .rst(rst), .issue(issue), .req(req),
      .busy(busy), .done(done), .hilo(hilo)
   );

   always #(CLK_PERIOD / 2) aclk = ~aclk;

   always @(posedge aclk) cyc <= cyc + 32'd1;   // edge index

   task automatic check(string name, logic [63:0] exp, logic [63:0] act);
      if (exp !== act) begin
         err_cnt++;
         $display("** Error: %s expected %h actual %h", name, exp, act);
         $display("Errors found");
         $fatal(1, "check %s failed", name);
      end
   endtask

   function automatic logic [63:0] mul_model(logic sgn, word_t a, word_t b);
      logic [63:0] xa;
      logic [63:0] xb;
      xa = sgn ? {{32{a[31]}}, a} : {32'd0, a};
      xb = sgn ? {{32{b[31]}}, b} : {32'd0, b};
      return xa * xb;   // low 64 bits are exact either way
   endfunction

   // remainder in the upper word, quotient in the lower
   function automatic logic [63:0] div_model(logic sgn, word_t a, word_t b);
      longint q;
      longint r;
      if (b == '0)
         return {a, 32'hffff_ffff};
      if (sgn) begin
         q = longint'($signed(a)) / longint'($signed(b));
         r = longint'($signed(a)) % longint'($signed(b));
      end else begin
         q = longint'({32'd0, a}) / longint'({32'd0, b});
         r = longint'({32'd0, a}) % longint'({32'd0, b});
      end
      return {r[31:0], q[31:0]};
   endfunction

   function automatic word_t pick_operand();
      case ($urandom_range(0, 5))
         0: return 32'h8000_0000;
         1: return 32'hffff_ffff;
         2: return 32'd1;
         3: return 32'd0;
         default: return $urandom;
      endcase
   endfunction

   // one request on the next falling edge
   task automatic drive(md_op_e op, word_t a, word_t b, bit accepted);
      pend_t e;
      @(negedge aclk);
      issue = 1'b1;
      req   = '{op: op, a: a, b: b};
      e.due = cyc + 32'd1;
      e.val = {32'd0, a};
      case (op)
         md_mult, md_multu: begin
            e.kind = K_MUL;
            e.due  = cyc + 32'd1 + 32'(MUL_STAGES);
            e.val  = mul_model(op == md_mult, a, b);
         end
         md_div, md_divu: begin
            e.kind = K_DIV;
            e.due  = cyc + 32'd1 + 32'(DIV_LAT);
            e.val  = div_model(op == md_div, a, b);
         end
         md_mthi: e.kind = K_HI;
         default: e.kind = K_LO;
      endcase
      if (accepted && op != md_none)
         pend.push_back(e);
   endtask

   task automatic release_bus();
      @(negedge aclk);
      issue = 1'b0;
      req   = '{op: md_none, a: $urandom, b: $urandom};
   endtask

   task automatic wait_idle();
      release_bus();
      @(posedge aclk);
      while (pend.size() != 0)
         @(posedge aclk);
   endtask

   // expected done, busy and HI/LO on every falling edge
   always @(negedge aclk) begin
      if (rst) begin
         // retire what the last rising edge wrote
         while (pend.size() != 0 && pend[0].due == cyc) begin
            head = pend.pop_front();
            case (head.kind)
               K_HI: model_hi = head.val[31:0];
               K_LO: model_lo = head.val[31:0];
               default: {model_hi, model_lo} = head.val;
            endcase
         end
         exp_done = 1'b0;
         exp_busy = 1'b0;
         if (pend.size() != 0) begin
            if (pend[0].kind <= K_DIV && pend[0].due == cyc + 32'd1)
               exp_done = 1'b1;
            if (pend[0].kind == K_DIV && cyc + 32'(DIV_LAT) >= pend[0].due
                && cyc + 32'd1 < pend[0].due)
               exp_busy = 1'b1;
         end
         check({test_name, " done"}, 64'(exp_done), 64'(done));
         check({test_name, " busy"}, 64'(exp_busy), 64'(busy));
         check({test_name, " hilo"}, {model_hi, model_lo}, hilo);
      end
   end

   initial begin
      #(TIMEOUT_CYC * CLK_PERIOD);
      $display("timeout: run did not finish within %0d cycles", TIMEOUT_CYC);
      $display("Errors found");
      $fatal(1, "watchdog expired");
   end

   initial begin
      void'($urandom(32'hf2d517ee));
      rst       = 1'b0;
      issue     = 1'b0;
      req       = '0;
      model_hi  = '0;
      model_lo  = '0;
      test_name = "reset";
      repeat (3) @(posedge aclk);
      @(negedge aclk);
      rst = 1'b1;

      test_name = "mul_rand";
      repeat (N_MUL) begin
         drive($urandom_range(0, 1) ? md_mult : md_multu, pick_operand(), $urandom, 1'b1);
         wait_idle();
      end

      test_name = "mul_burst";   // one multiply per cycle
      repeat (N_BURST) begin
         repeat (MUL_STAGES + 2)
            drive($urandom_range(0, 1) ? md_mult : md_multu, $urandom, $urandom, 1'b1);
         wait_idle();
      end

      test_name = "div_rand";
      repeat (N_DIV) begin
         drive($urandom_range(0, 1) ? md_div : md_divu, pick_operand(), pick_operand(), 1'b1);
         wait_idle();
      end

      test_name = "div_corner";
      drive(md_div, 32'h8000_0000, 32'hffff_ffff, 1'b1);
      wait_idle();
      drive(md_div, 32'hffff_fff9, 32'd0, 1'b1);   // negative over zero
      wait_idle();
      drive(md_div, 32'd12345, 32'd0, 1'b1);
      wait_idle();
      drive(md_divu, 32'h8000_0000, 32'd0, 1'b1);
      wait_idle();
      drive(md_divu, 32'h8000_0000, 32'd1, 1'b1);
      wait_idle();

      test_name = "mt_rand";
      repeat (N_MT) begin
         drive($urandom_range(0, 1) ? md_mthi : md_mtlo, $urandom, $urandom, 1'b1);
         wait_idle();
      end

      test_name = "busy_issue";
      repeat (N_BUSY) begin
         drive(md_div, $urandom, pick_operand(), 1'b1);
         release_bus();
         repeat ($urandom_range(0, 28)) @(negedge aclk);
         drive(md_op_e'(3'($urandom_range(1, 6))), $urandom, $urandom, 1'b0);
         wait_idle();
      end

      release_bus();
      if (err_cnt == 0)
         $display("No errors");
      else
         $display("Errors found");
      $finish;
   end

endmodule

`default_nettype wire

// File: muldiv_unit.f
// multiply/divide unit, package first, then RTL, then testbench
rtl/muldiv_pkg.sv
rtl/mul_pipe.sv
rtl/div_iter.sv
rtl/hilo_regs.sv
rtl/muldiv_ctrl.sv
rtl/muldiv_top.sv
sim/tb_muldiv.sv

// File: Makefile
SRCS = rtl/muldiv_pkg.sv rtl/mul_pipe.sv rtl/div_iter.sv rtl/hilo_regs.sv \
       rtl/muldiv_ctrl.sv rtl/muldiv_top.sv sim/tb_muldiv.sv

.PHONY: run check-log clean

run: obj_dir/Vtb_muldiv
	-./obj_dir/Vtb_muldiv > sim.log 2>&1
	@cat sim.log
	@$(MAKE) --no-print-directory check-log

obj_dir/Vtb_muldiv: muldiv_unit.f $(SRCS)
	verilator --binary --assert -Wno-fatal -f muldiv_unit.f --top-module tb_muldiv -o Vtb_muldiv

check-log:
	@if grep -q "Errors found" sim.log; then echo "simulation FAILED"; exit 1; \
	elif grep -q "No errors" sim.log; then echo "simulation passed"; \
	else echo "simulation log incomplete"; exit 1; fi

clean:
	rm -rf obj_dir sim.log
